// File: axil_monitor_patterns.txt
// Columns, all hex: op arg ctrl data. op 0 drives the channels for arg cycles, op 1 reads
// register arg and expects data, op 2 writes data to register arg, op 3 expects o_irq = data[0]
// ctrl bit 10 draws new random payloads, bits 9..0 are awvalid awready wvalid wready bvalid
// bready arvalid arready rvalid rready. For op 0, data bits 1:0 are bresp and 3:2 rresp
0 02 000 00000000
// Legal write and read
0 01 7C0 00000000
0 02 000 00000000
0 01 40C 00000000
0 01 000 00000000
1 01 000 00000111
0 01 433 00000000
0 02 000 00000000
1 01 000 00000000
1 00 000 00000000
3 00 000 00000000
// AW payload moves while stalled, R drops valid while stalled
0 02 600 00000000
0 01 600 00000000
0 01 3C0 00000000
0 01 030 00000000
0 02 002 00000000
0 02 000 00000000
1 00 000 00400400
3 00 000 00000001
2 00 000 007FFFFF
1 00 000 00000000
3 00 000 00000000
// Orphan write response, EXOKAY read response
0 01 030 00000000
0 01 00C 00000000
0 01 003 00000004
0 02 000 00000000
1 00 000 00000021
2 00 000 007FFFFF
1 00 000 00000000
// AR stall and write wait of 11 cycles are legal
0 0B 408 00000000
0 01 00C 00000000
0 01 003 00000000
0 01 3C0 00000000
0 0B 000 00000000
0 01 030 00000000
0 02 000 00000000
1 00 000 00000000
// 12 cycles set ar stall and wr_timeout
0 0C 408 00000000
0 01 00C 00000000
0 01 003 00000000
0 01 3C0 00000000
0 0C 000 00000000
0 01 030 00000000
0 02 000 00000000
1 00 000 00001008
3 00 000 00000001
2 00 000 007FFFFF
// Fifteen reads, rd_overflow and rd_timeout
0 0F 40C 00000000
0 02 000 00000000
1 01 000 0000000E
1 00 000 00000044
3 00 000 00000001
// Partial clear, ignored write, full clear
2 00 000 00000004
2 01 000 007FFFFF
1 00 000 00000040
3 00 000 00000001
2 00 000 007FFFFF
1 00 000 00000000
3 00 000 00000000
1 03 000 00000000
F 00 000 00000000

// File: tb.f
axil_mon_pkg.sv
axil_chan_watch.sv
axil_txn_counter.sv
axil_write_tracker.sv
axil_read_tracker.sv
axil_mon_regs.sv
axil_monitor.sv
tb_axil_monitor.sv

// File: Bender.yml
package:
  name: axil_monitor

sources:
  - files:
      - axil_mon_pkg.sv
      - axil_chan_watch.sv
      - axil_txn_counter.sv
      - axil_write_tracker.sv
      - axil_read_tracker.sv
      - axil_mon_regs.sv
      - axil_monitor.sv
  - target: simulation
    files:
      - tb_axil_monitor.sv

// File: tb_axil_monitor.sv
`timescale 1ns/1ns
// Replays axil_monitor_patterns.txt from the project root, four hex words per record
// Status, counts and o_irq are only compared where a record asks for it
module tb_axil_monitor
	import axil_mon_pkg::*;
();

	// AXI-lite link, all driven by the testbench
	logic i_clk;
	logic i_axi_reset_n;
	logic i_axi_awvalid;
	logic i_axi_awready;
	logic i_axi_wvalid;
	logic i_axi_wready;
	logic i_axi_bvalid;
	logic i_axi_bready;
	logic i_axi_arvalid;
	logic i_axi_arready;
	logic i_axi_rvalid;
	logic i_axi_rready;
	axil_addr_t  i_axi_aw;
	axil_addr_t  i_axi_ar;
	axil_wdata_t i_axi_w;
	axil_rdata_t i_axi_r;
	axil_bresp_t i_axi_b;

	// Register port
	logic                 i_wb_cyc;
	logic                 i_wb_stb;
	logic                 i_wb_we;
	logic [WB_ADDR_W-1:0] i_wb_adr;
	logic [DATA_W-1:0]    i_wb_dat;
	logic [DATA_W-1:0]    o_wb_dat;
	logic                 o_wb_ack;
	logic                 o_irq;

	// Records of op, arg, ctrl, data
	logic [31:0] pat_mem [0:511];
	int          n_rec;
	int          pass_count;
	int          fail_count;
	logic        records_ready;
	logic [31:0] lcg_state;

	axil_monitor UUT (.*);

	// 20 ns clock
	initial
	begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////
	// Random payloads
	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		lcg_step = state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_random(output logic [31:0] value);
		lcg_state = lcg_step(lcg_state);
		value = lcg_state;
	endtask

	// Response codes are left to the pattern
	task automatic fill_payloads();
		logic [31:0] rnd;
		draw_random(rnd);
		i_axi_aw.addr = rnd[ADDR_W-1:0];
		i_axi_aw.prot = rnd[31:29];
		draw_random(rnd);
		i_axi_ar.addr = rnd[ADDR_W-1:0];
		i_axi_ar.prot = rnd[31:29];
		draw_random(rnd);
		i_axi_w.data = rnd;
		draw_random(rnd);
		i_axi_w.strb = rnd[STRB_W-1:0];
		draw_random(rnd);
		i_axi_r.data = rnd;
	endtask

	////////////////////////////////////////////////////////////
	// Drivers, always entered 2 ns after a rising edge
	task automatic drive_channels(input logic [11:0] ctrl, input logic [31:0] resp_bits,
		input int cycles);
		if (ctrl[10])
			fill_payloads();
		i_axi_b.resp = resp_bits[1:0];
		i_axi_r.resp = resp_bits[3:2];
		{i_axi_awvalid, i_axi_awready, i_axi_wvalid, i_axi_wready, i_axi_bvalid,
			i_axi_bready, i_axi_arvalid, i_axi_arready, i_axi_rvalid,
			i_axi_rready} = ctrl[9:0];
		repeat (cycles)
		begin
			@(posedge i_clk);
			#2;
		end
	endtask

	// Classic cycle, master holds cyc and stb until ack
	task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat, output logic acked);
		int waited;
		waited   = 0;
		acked    = 1'b0;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		while (!acked && waited < 4)
		begin
			@(posedge i_clk);
			#2;
			waited = waited + 1;
			acked  = o_wb_ack;
		end
		rdat     = o_wb_dat;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Checks
	task automatic check_register(input int idx, input logic [WB_ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] expected);
		logic [DATA_W-1:0] rdata;
		logic              acked;
		wb_access(1'b0, adr, '0, rdata, acked);
		if (!acked)
		begin
			$display("Record %0d: read of register %0d got no Wishbone ack", idx, adr);
			fail_count = fail_count + 1;
		end
		else if (rdata !== expected)
		begin
			$display("[ERROR] %0t ns: record %0d register %0d expected %h, read %h",
				$time, idx, adr, expected, rdata);
			fail_count = fail_count + 1;
		end
		else
		begin
			$display("Record %0d: register %0d read %h, ok", idx, adr, rdata);
			pass_count = pass_count + 1;
		end
	endtask

	task automatic check_irq(input int idx, input logic expected);
		if (o_irq !== expected)
		begin
			$display("[ERROR] %0t ns: record %0d o_irq expected %b, read %b",
				$time, idx, expected, o_irq);
			fail_count = fail_count + 1;
		end
		else
		begin
			$display("Record %0d: o_irq is %b, ok", idx, o_irq);
			pass_count = pass_count + 1;
		end
	endtask

	task automatic write_register(input int idx, input logic [WB_ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdat);
		logic [DATA_W-1:0] rdata;
		logic              acked;
		wb_access(1'b1, adr, wdat, rdata, acked);
		if (!acked)
		begin
			$display("Record %0d: write to register %0d got no Wishbone ack", idx, adr);
			fail_count = fail_count + 1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	initial
	begin
		int   idx;
		logic found_end;
		logic bad_word;
		i_axi_reset_n = 1'b0;
		{i_axi_awvalid, i_axi_awready, i_axi_wvalid, i_axi_wready, i_axi_bvalid} = '0;
		{i_axi_bready, i_axi_arvalid, i_axi_arready, i_axi_rvalid, i_axi_rready} = '0;
		i_axi_aw = '0;
		i_axi_ar = '0;
		i_axi_w  = '0;
		i_axi_r  = '0;
		i_axi_b  = '0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		pass_count    = 0;
		fail_count    = 0;
		records_ready = 1'b0;
		lcg_state     = 32'hd9687103;

		$readmemh("axil_monitor_patterns.txt", pat_mem);
		// Records end with opcode F
		n_rec     = 0;
		found_end = 1'b0;
		bad_word  = 1'b0;
		while (n_rec < 128 && !found_end && !bad_word)
		begin
			if (pat_mem[4*n_rec] === 32'hF)
				found_end = 1'b1;
			else if ($isunknown(pat_mem[4*n_rec]))
				bad_word = 1'b1;
			else
				n_rec = n_rec + 1;
		end

		if (found_end)
		begin
			records_ready = 1'b1;
			// Reset for 2 cycles, released just after an edge
			repeat (2) @(posedge i_clk);
			#2;
			i_axi_reset_n = 1'b1;
			for (idx = 0; idx < n_rec; idx++)
			begin
				case (pat_mem[4*idx][3:0])
					4'h0: drive_channels(pat_mem[4*idx+2][11:0], pat_mem[4*idx+3],
						pat_mem[4*idx+1]);
					4'h1: check_register(idx, pat_mem[4*idx+1][WB_ADDR_W-1:0],
						pat_mem[4*idx+3]);
					4'h2: write_register(idx, pat_mem[4*idx+1][WB_ADDR_W-1:0],
						pat_mem[4*idx+3]);
					4'h3: check_irq(idx, pat_mem[4*idx+3][0]);
					default:
					begin
						$display("Record %0d has an unknown opcode", idx);
						fail_count = fail_count + 1;
					end
				endcase
			end
		end
		else
		begin
			$display("Pattern file is missing, unreadable or has no end record");
			fail_count = fail_count + 1;
		end

		$display("%0d checks passed, %0d checks failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// 40 cycles per record is far beyond any record's length
	initial
	begin
		wait (records_ready);
		#(n_rec * 40 * 20);
		$display("Watchdog expired after %0d records, the run is stuck", n_rec);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: axil_monitor.sv
`timescale 1ns/1ns
// Passive AXI-lite monitor, every AXI signal is an input
// Violations are sticky in the status register and raise o_irq
module axil_monitor
	import axil_mon_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	// Write address
	input  logic                 i_axi_awvalid,
	input  logic                 i_axi_awready,
	input  axil_addr_t           i_axi_aw,
	// Write data
	input  logic                 i_axi_wvalid,
	input  logic                 i_axi_wready,
	input  axil_wdata_t          i_axi_w,
	// Write response
	input  logic                 i_axi_bvalid,
	input  logic                 i_axi_bready,
	input  axil_bresp_t          i_axi_b,
	// Read address
	input  logic                 i_axi_arvalid,
	input  logic                 i_axi_arready,
	input  axil_addr_t           i_axi_ar,
	// Read data
	input  logic                 i_axi_rvalid,
	input  logic                 i_axi_rready,
	input  axil_rdata_t          i_axi_r,
	// Register port
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  logic [WB_ADDR_W-1:0] i_wb_adr,
	input  logic [DATA_W-1:0]    i_wb_dat,
	output logic [DATA_W-1:0]    o_wb_dat,
	output logic                 o_wb_ack,
	output logic                 o_irq
);

	// Handshakes count only outside reset
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic ar_fire;
	logic r_fire;

	chan_viol_t aw_viol;
	chan_viol_t w_viol;
	chan_viol_t b_viol;
	chan_viol_t ar_viol;
	chan_viol_t r_viol;

	axil_viol_t wr_viol;
	axil_viol_t rd_viol;
	axil_viol_t viol;

	logic [LGDEPTH-1:0] aw_count;
	logic [LGDEPTH-1:0] w_count;
	logic [LGDEPTH-1:0] ar_count;
	axil_counts_t       counts;

	assign aw_fire = i_axi_awvalid && i_axi_awready && i_axi_reset_n;
	assign w_fire  = i_axi_wvalid && i_axi_wready && i_axi_reset_n;
	assign b_fire  = i_axi_bvalid && i_axi_bready && i_axi_reset_n;
	assign ar_fire = i_axi_arvalid && i_axi_arready && i_axi_reset_n;
	assign r_fire  = i_axi_rvalid && i_axi_rready && i_axi_reset_n;

	////////////////////////////////////////////////////////////
	// Channel watchers
	// Request stalls are excused by a pending response
	axil_chan_watch #(.payload_t(axil_addr_t), .STALL_LIMIT(MAX_WAIT)) u_aw_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_awvalid),
		.i_ready(i_axi_awready), .i_payload(i_axi_aw), .i_blocked(i_axi_bvalid),
		.o_viol(aw_viol)
	);

	axil_chan_watch #(.payload_t(axil_wdata_t), .STALL_LIMIT(MAX_WAIT)) u_w_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_wvalid),
		.i_ready(i_axi_wready), .i_payload(i_axi_w), .i_blocked(i_axi_bvalid),
		.o_viol(w_viol)
	);

	axil_chan_watch #(.payload_t(axil_addr_t), .STALL_LIMIT(MAX_WAIT)) u_ar_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_arvalid),
		.i_ready(i_axi_arready), .i_payload(i_axi_ar), .i_blocked(i_axi_rvalid),
		.o_viol(ar_viol)
	);

	// Response channels are never excused
	axil_chan_watch #(.payload_t(axil_bresp_t), .STALL_LIMIT(MAX_RSTALL)) u_b_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_bvalid),
		.i_ready(i_axi_bready), .i_payload(i_axi_b), .i_blocked(1'b0),
		.o_viol(b_viol)
	);

	axil_chan_watch #(.payload_t(axil_rdata_t), .STALL_LIMIT(MAX_RSTALL)) u_r_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_rvalid),
		.i_ready(i_axi_rready), .i_payload(i_axi_r), .i_blocked(1'b0),
		.o_viol(r_viol)
	);

	////////////////////////////////////////////////////////////
	// Transaction trackers
	axil_write_tracker u_write_tracker (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_aw_fire(aw_fire),
		.i_w_fire(w_fire), .i_b_fire(b_fire), .i_bvalid(i_axi_bvalid),
		.i_bresp(i_axi_b), .o_aw_count(aw_count), .o_w_count(w_count),
		.o_viol(wr_viol)
	);

	axil_read_tracker u_read_tracker (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_ar_fire(ar_fire),
		.i_r_fire(r_fire), .i_rvalid(i_axi_rvalid), .i_rresp(i_axi_r.resp),
		.o_ar_count(ar_count), .o_viol(rd_viol)
	);

	// Trackers leave their unused fields at zero, so an OR merges them
	always_comb
	begin
		viol    = axil_viol_t'(wr_viol | rd_viol);
		viol.aw = aw_viol;
		viol.w  = w_viol;
		viol.b  = b_viol;
		viol.ar = ar_viol;
		viol.r  = r_viol;
	end

	always_comb
	begin
		counts.aw = aw_count;
		counts.w  = w_count;
		counts.ar = ar_count;
	end

	axil_mon_regs u_regs (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_viol(viol), .i_counts(counts),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .o_irq(o_irq)
	);

endmodule

// File: axil_mon_regs.sv
`timescale 1ns/1ns
// Wishbone classic slave, ack one cycle after cyc and stb, no wait states
// Status is write-one-to-clear. A new pulse beats a clear on the same bit
module axil_mon_regs
	import axil_mon_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	input  axil_viol_t           i_viol,
	input  axil_counts_t         i_counts,
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  logic [WB_ADDR_W-1:0] i_wb_adr,
	input  logic [DATA_W-1:0]    i_wb_dat,
	output logic [DATA_W-1:0]    o_wb_dat,
	output logic                 o_wb_ack,
	output logic                 o_irq
);

	// Sticky status
	axil_viol_t r_status;
	axil_viol_t w_clear;
	axil_viol_t w_status_next;

	logic              w_req;
	logic [DATA_W-1:0] w_rdata;

	// New access, ack low so it is only taken once
	assign w_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

	////////////////////////////////////////////////////////////
	// Status update
	always_comb
	begin
		w_clear = '0;
		if (w_req && i_wb_we && (i_wb_adr == REG_STATUS))
			w_clear = axil_viol_t'(i_wb_dat[VIOL_W-1:0]);
		// Set after clear, so the set wins
		w_status_next = axil_viol_t'((r_status & ~w_clear) | i_viol);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			r_status <= '0;
			o_irq    <= 1'b0;
		end
		else
		begin
			r_status <= w_status_next;
			// Follows status on the same edge
			o_irq    <= |w_status_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Read mux, unmapped words read zero
	always_comb
	begin
		w_rdata = '0;
		case (i_wb_adr)
			REG_STATUS:
				w_rdata[VIOL_W-1:0] = r_status;
			REG_OUTSTANDING:
				w_rdata[COUNTS_W-1:0] = i_counts;
			default:
				w_rdata = '0;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= w_req;
	end

	// Captured with the ack, writes return zero
	always_ff @(posedge i_clk)
	begin
		if (w_req)
			o_wb_dat <= i_wb_we ? '0 : w_rdata;
	end

endmodule

// File: axil_read_tracker.sv
`timescale 1ns/1ns
// Only the read fields of o_viol are driven, the rest stay zero
module axil_read_tracker
	import axil_mon_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_axi_reset_n,
	input  logic               i_ar_fire,
	input  logic               i_r_fire,
	input  logic               i_rvalid,
	input  logic [1:0]         i_rresp,
	output logic [LGDEPTH-1:0] o_ar_count,
	output axil_viol_t         o_viol
);

	logic ar_overflow;
	logic ar_orphan;

	logic [TIMER_W-1:0] r_delay;
	logic r_timeout;
	logic r_bad_resp;
	logic w_waiting;

	// Read requests retired by each R handshake
	axil_txn_counter u_ar_count (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_req         (i_ar_fire),
		.i_ack         (i_r_fire),
		.o_count       (o_ar_count),
		.o_overflow    (ar_overflow),
		.o_orphan      (ar_orphan)
	);

	////////////////////////////////////////////////////////////
	// Request to response delay, held at zero while rvalid
	assign w_waiting = (o_ar_count != '0) && !i_rvalid;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !w_waiting)
			r_delay <= '0;
		else if (r_delay != TIMER_W'(MAX_DELAY))
			r_delay <= r_delay + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			r_timeout  <= 1'b0;
			r_bad_resp <= 1'b0;
		end
		else
		begin
			r_timeout  <= w_waiting && (r_delay == TIMER_W'(MAX_DELAY - 1));
			r_bad_resp <= i_rvalid && (i_rresp == RESP_EXOKAY);
		end
	end

	always_comb
	begin
		o_viol             = '0;
		o_viol.rd_overflow = ar_overflow;
		o_viol.rd_orphan   = ar_orphan;
		o_viol.rd_timeout  = r_timeout;
		o_viol.bad_rresp   = r_bad_resp;
	end

endmodule

// File: axil_write_tracker.sv
`timescale 1ns/1ns
// Only the write fields of o_viol are driven, the rest stay zero
// Delay timer waits on both address and data being outstanding
module axil_write_tracker
	import axil_mon_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_axi_reset_n,
	input  logic               i_aw_fire,
	input  logic               i_w_fire,
	input  logic               i_b_fire,
	input  logic               i_bvalid,
	input  axil_bresp_t        i_bresp,
	output logic [LGDEPTH-1:0] o_aw_count,
	output logic [LGDEPTH-1:0] o_w_count,
	output axil_viol_t         o_viol
);

	logic aw_overflow;
	logic aw_orphan;
	logic w_overflow;
	logic w_orphan;

	logic [TIMER_W-1:0] r_delay;
	logic r_timeout;
	logic r_bad_resp;
	logic w_waiting;

	////////////////////////////////////////////////////////////
	// Outstanding counters, each retired by the write response
	axil_txn_counter u_aw_count (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_req         (i_aw_fire),
		.i_ack         (i_b_fire),
		.o_count       (o_aw_count),
		.o_overflow    (aw_overflow),
		.o_orphan      (aw_orphan)
	);

	axil_txn_counter u_w_count (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_req         (i_w_fire),
		.i_ack         (i_b_fire),
		.o_count       (o_w_count),
		.o_overflow    (w_overflow),
		.o_orphan      (w_orphan)
	);

	////////////////////////////////////////////////////////////
	// Request to response delay
	// A pending bvalid holds the timer at zero
	assign w_waiting = (o_aw_count != '0) && (o_w_count != '0) && !i_bvalid;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !w_waiting)
			r_delay <= '0;
		else if (r_delay != TIMER_W'(MAX_DELAY))
			r_delay <= r_delay + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			r_timeout  <= 1'b0;
			r_bad_resp <= 1'b0;
		end
		else
		begin
			r_timeout  <= w_waiting && (r_delay == TIMER_W'(MAX_DELAY - 1));
			r_bad_resp <= i_bvalid && (i_bresp.resp == RESP_EXOKAY);
		end
	end

	// Flags from both counters merge into one write flag each
	always_comb
	begin
		o_viol             = '0;
		o_viol.wr_overflow = aw_overflow || w_overflow;
		o_viol.wr_orphan   = aw_orphan || w_orphan;
		o_viol.wr_timeout  = r_timeout;
		o_viol.bad_bresp   = r_bad_resp;
	end

endmodule

// File: axil_txn_counter.sv
`timescale 1ns/1ns
// Count saturates at MAX_OUTSTANDING and never wraps below zero
module axil_txn_counter
	import axil_mon_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_axi_reset_n,
	input  logic               i_req,
	input  logic               i_ack,
	output logic [LGDEPTH-1:0] o_count,
	output logic               o_overflow,
	output logic               o_orphan
);

	logic w_full;
	logic w_empty;

	assign w_full  = (o_count == LGDEPTH'(MAX_OUTSTANDING));
	assign w_empty = (o_count == '0);

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_count    <= '0;
			o_overflow <= 1'b0;
			o_orphan   <= 1'b0;
		end
		else
		begin
			// One more request than the slave may hold
			o_overflow <= i_req && !i_ack && w_full;
			// A response with nothing to answer
			o_orphan <= i_ack && w_empty;
			case ({i_req, i_ack})
				2'b10:
					if (!w_full)
						o_count <= o_count + 1'b1;
				2'b01:
					if (!w_empty)
						o_count <= o_count - 1'b1;
				// Both or neither leave the count alone
				default:
					o_count <= o_count;
			endcase
		end
	end

endmodule

// File: axil_chan_watch.sv
`timescale 1ns/1ns
// Observes one channel and never drives it. STALL_LIMIT must fit in TIMER_W bits
// Flags are one-cycle pulses registered at the offending edge
module axil_chan_watch
	import axil_mon_pkg::*;
#(
	parameter type payload_t = axil_addr_t,
	parameter int STALL_LIMIT = MAX_WAIT
) (
	input  logic       i_clk,
	input  logic       i_axi_reset_n,
	input  logic       i_valid,
	input  logic       i_ready,
	input  payload_t   i_payload,
	input  logic       i_blocked,
	output chan_viol_t o_viol
);

	// Channel stalled on the last edge, and what it held then
	logic     r_stalled;
	payload_t r_payload;
	// Set during reset, so it marks the first cycle after release
	logic     r_in_reset;
	// Consecutive stalled cycles
	logic [TIMER_W-1:0] r_stall_timer;

	logic w_stalled;
	logic w_stall_count;

	assign w_stalled = i_valid && !i_ready;
	// Back-pressure from the response side excuses the stall
	assign w_stall_count = w_stalled && !i_blocked;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			r_stalled  <= 1'b0;
			r_in_reset <= 1'b1;
		end
		else
		begin
			r_stalled  <= w_stalled;
			r_in_reset <= 1'b0;
		end
	end

	// Only a stalled payload is ever compared
	always_ff @(posedge i_clk)
	begin
		if (w_stalled)
			r_payload <= i_payload;
	end

	////////////////////////////////////////////////////////////
	// Stall timer, saturates at the limit
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !w_stall_count)
			r_stall_timer <= '0;
		else if (r_stall_timer != TIMER_W'(STALL_LIMIT))
			r_stall_timer <= r_stall_timer + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Violation pulses
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_viol <= '0;
		else
		begin
			// Valid dropped or payload moved while stalled
			o_viol.unstable <= r_stalled && (!i_valid || (i_payload != r_payload));
			// Pulse once, on the edge the timer reaches the limit
			o_viol.stall <= w_stall_count
				&& (r_stall_timer == TIMER_W'(STALL_LIMIT - 1));
			o_viol.reset_valid <= r_in_reset && i_valid;
		end
	end

endmodule

// File: axil_mon_pkg.sv
// Widths and limits are fixed for the whole monitor. TIMER_W must hold the largest limit
// Status bits follow the field order of axil_viol_t, most significant field first
package axil_mon_pkg;

	////////////////////////////////////////////////////////////
	// AXI-lite field widths
	localparam int ADDR_W = 28;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// Outstanding counter width and its highest legal value
	localparam int LGDEPTH = 4;
	localparam int MAX_OUTSTANDING = 14;

	// Stall limits for request and response channels
	localparam int MAX_WAIT = 12;
	localparam int MAX_RSTALL = 12;
	// Request to response limit
	localparam int MAX_DELAY = 12;

	// Largest of the three limits sizes every timer
	localparam int MAX_LIMIT_WD = (MAX_WAIT > MAX_DELAY) ? MAX_WAIT : MAX_DELAY;
	localparam int MAX_LIMIT = (MAX_RSTALL > MAX_LIMIT_WD) ? MAX_RSTALL : MAX_LIMIT_WD;
	localparam int TIMER_W = $clog2(MAX_LIMIT + 1);

	////////////////////////////////////////////////////////////
	// Register port
	localparam int WB_ADDR_W = 2;
	localparam logic [WB_ADDR_W-1:0] REG_STATUS = 2'd0;
	localparam logic [WB_ADDR_W-1:0] REG_OUTSTANDING = 2'd1;

	// Exclusive access is never legal on AXI-lite
	localparam logic [1:0] RESP_EXOKAY = 2'b01;

	////////////////////////////////////////////////////////////
	// Channel payloads
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        prot;
	} axil_addr_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axil_wdata_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
	} axil_rdata_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_bresp_t;

	// Per channel flags
	typedef struct packed {
		logic unstable;
		logic stall;
		logic reset_valid;
	} chan_viol_t;

	// Full violation vector, also the status register layout
	typedef struct packed {
		chan_viol_t aw;
		chan_viol_t w;
		chan_viol_t b;
		chan_viol_t ar;
		chan_viol_t r;
		logic       wr_overflow;
		logic       rd_overflow;
		logic       wr_orphan;
		logic       rd_orphan;
		logic       wr_timeout;
		logic       rd_timeout;
		logic       bad_bresp;
		logic       bad_rresp;
	} axil_viol_t;

	// Outstanding counts, aw in the top nibble
	typedef struct packed {
		logic [LGDEPTH-1:0] aw;
		logic [LGDEPTH-1:0] w;
		logic [LGDEPTH-1:0] ar;
	} axil_counts_t;

	localparam int VIOL_W = $bits(axil_viol_t);
	localparam int COUNTS_W = $bits(axil_counts_t);

endpackage
